//--- Bender.yml
package:
  name: openadc_core

sources:
  - hdl/openadc_pkg.sv
  - hdl/adc_front.sv
  - hdl/level_trigger.sv
  - hdl/capture_buffer.sv
  - hdl/openadc_regs.sv
  - hdl/openadc_core.sv
  - target: simulation
    files:
      - sim/openadc_checker.sv
      - sim/tb_openadc.sv

//--- compile.f
hdl/openadc_pkg.sv
hdl/adc_front.sv
hdl/level_trigger.sv
hdl/capture_buffer.sv
hdl/openadc_regs.sv
hdl/openadc_core.sv
sim/openadc_checker.sv
sim/tb_openadc.sv

//--- hdl/adc_front.sv
`default_nettype none

module adc_front (
   input  wire                               clk_usb,
   input  wire                               reset,
   input  wire [openadc_pkg::SAMPLE_W-1:0]   adc_data_i,
   input  wire                               adc_valid_i,
   input  wire                               use_adc_i,
   output logic [openadc_pkg::SAMPLE_W-1:0]  sample_o,
   output logic                              sample_valid_o
);

   logic [openadc_pkg::SAMPLE_W-1:0] pattern_cnt;   // counting test pattern
   logic [openadc_pkg::SAMPLE_W-1:0] stage1_data;
   logic                             stage1_valid;

   // one step per valid input, wraps at 4096
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pattern_cnt <= '0;
      end else if (adc_valid_i) begin
         pattern_cnt <= pattern_cnt + 1'b1;
      end
   end

   // stage 1: pick the source
   always_ff @(posedge clk_usb) begin
      if (adc_valid_i) begin
         stage1_data <= use_adc_i ? adc_data_i : pattern_cnt;
      end
   end

   // stage 2: resample, keeps the path short ahead of the compare
   always_ff @(posedge clk_usb) begin
      if (stage1_valid) begin
         sample_o <= stage1_data;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         stage1_valid   <= 1'b0;
         sample_valid_o <= 1'b0;
      end else begin
         stage1_valid   <= adc_valid_i;
         sample_valid_o <= stage1_valid;   // valid rides with the data
      end
   end

endmodule

`default_nettype wire

//--- hdl/capture_buffer.sv
`default_nettype none

module capture_buffer (
   input  wire                               clk_usb,
   input  wire                               reset,
   input  wire [openadc_pkg::SAMPLE_W-1:0]   sample_i,
   input  wire                               sample_valid_i,
   input  wire                               trig_pulse_i,
   input  wire [openadc_pkg::LEN_W-1:0]      capture_len_i,
   input  wire                               arm_i,
   input  wire                               sample_ready_i,
   output logic [openadc_pkg::SAMPLE_W-1:0]  sample_o,
   output logic                              sample_valid_o,
   output logic                              capture_active_o,
   output logic                              overflow_o
);

   openadc_pkg::cap_state_e          state_q;
   logic [openadc_pkg::LEN_W-1:0]    remain_q;   // samples still to take
   logic [openadc_pkg::SAMPLE_W-1:0] mem [openadc_pkg::FIFO_DEPTH];
   logic [openadc_pkg::FIFO_AW-1:0]  wr_ptr;
   logic [openadc_pkg::FIFO_AW-1:0]  rd_ptr;
   logic [openadc_pkg::FIFO_AW:0]    fill;
   logic                             start;
   logic                             take;
   logic                             full;
   logic                             empty;
   logic                             wr_en;
   logic                             rd_en;

   assign start = sample_valid_i && trig_pulse_i && (state_q == openadc_pkg::CAP_IDLE);
   assign take  = start || (sample_valid_i && (state_q == openadc_pkg::CAP_RUN));
   assign full  = (fill == openadc_pkg::FIFO_DEPTH);
   assign empty = (fill == '0);
   assign wr_en = take && !full;
   assign rd_en = !empty && (!sample_valid_o || sample_ready_i);   // refill output reg

   assign capture_active_o = trig_pulse_i || (state_q == openadc_pkg::CAP_RUN);

   // length 0 and 1 both end on the trigger sample
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q  <= openadc_pkg::CAP_IDLE;
         remain_q <= '0;
      end else if (start) begin
         if (capture_len_i > 1) begin
            state_q  <= openadc_pkg::CAP_RUN;
            remain_q <= capture_len_i - 1'b1;
         end
      end else if ((state_q == openadc_pkg::CAP_RUN) && sample_valid_i) begin
         remain_q <= remain_q - 1'b1;
         if (remain_q == 1) begin
            state_q <= openadc_pkg::CAP_IDLE;   // last sample taken
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (wr_en) begin
         mem[wr_ptr] <= sample_i;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // output register holds its value while stalled
   always_ff @(posedge clk_usb) begin
      if (rd_en) begin
         sample_o <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sample_valid_o <= 1'b0;
      end else if (rd_en) begin
         sample_valid_o <= 1'b1;
      end else if (sample_ready_i) begin
         sample_valid_o <= 1'b0;
      end
   end

   // a dropped sample sets the flag until re-armed
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         overflow_o <= 1'b0;
      end else if (arm_i) begin
         overflow_o <= 1'b0;
      end else if (take && full) begin
         overflow_o <= 1'b1;
      end
   end

   a_no_write_full : assert property (@(posedge clk_usb) disable iff (reset)
      (fill <= openadc_pkg::FIFO_DEPTH) &&
      (fill[openadc_pkg::FIFO_AW-1:0] == (wr_ptr - rd_ptr)));

   a_hold_on_stall : assert property (@(posedge clk_usb) disable iff (reset)
      (sample_valid_o && !sample_ready_i) |=> (sample_valid_o && $stable(sample_o)));

endmodule

`default_nettype wire

//--- hdl/level_trigger.sv
`default_nettype none

module level_trigger (
   input  wire                               clk_usb,
   input  wire                               reset,
   input  wire [openadc_pkg::SAMPLE_W-1:0]   sample_i,
   input  wire                               sample_valid_i,
   input  wire [openadc_pkg::SAMPLE_W-1:0]   trig_level_i,
   input  wire                               arm_i,
   output logic [openadc_pkg::SAMPLE_W-1:0]  sample_o,
   output logic                              sample_valid_o,
   output logic                              trig_pulse_o,
   output logic                              armed_o
);

   openadc_pkg::cap_state_e state_q;
   logic                    hit;
   logic                    fire;

   // level msb picks the direction, compare is strict
   always_comb begin
      if (trig_level_i[openadc_pkg::SAMPLE_W-1]) begin
         hit = (sample_i > trig_level_i);
      end else begin
         hit = (sample_i < trig_level_i);
      end
   end

   // an arm in this cycle restarts the wait for the next sample
   assign fire = (state_q == openadc_pkg::CAP_ARMED) && sample_valid_i && hit && !arm_i;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q <= openadc_pkg::CAP_IDLE;
      end else if (arm_i) begin
         state_q <= openadc_pkg::CAP_ARMED;
      end else if (fire) begin
         state_q <= openadc_pkg::CAP_IDLE;   // one shot
      end
   end

   // third register stage, pulse lines up with its sample
   always_ff @(posedge clk_usb) begin
      sample_o <= sample_i;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sample_valid_o <= 1'b0;
         trig_pulse_o   <= 1'b0;
      end else begin
         sample_valid_o <= sample_valid_i;
         trig_pulse_o   <= fire;
      end
   end

   // drops the cycle after the pulse
   assign armed_o = (state_q == openadc_pkg::CAP_ARMED) || trig_pulse_o;

   a_single_pulse : assert property (@(posedge clk_usb) disable iff (reset)
      trig_pulse_o |=> !trig_pulse_o);

   a_pulse_on_sample : assert property (@(posedge clk_usb) disable iff (reset)
      trig_pulse_o |-> sample_valid_o);

endmodule

`default_nettype wire

//--- hdl/openadc_core.sv
`default_nettype none

module openadc_core (
   input  wire                               clk_usb,
   input  wire                               reset,
   input  wire [openadc_pkg::SAMPLE_W-1:0]   adc_data_i,
   input  wire                               adc_valid_i,
   input  wire [openadc_pkg::ADDR_W-1:0]     reg_address_i,
   input  wire [openadc_pkg::BYTE_W-1:0]     reg_datai_i,
   input  wire                               reg_write_i,
   input  wire                               sample_ready_i,
   output wire [openadc_pkg::BYTE_W-1:0]     reg_datao_o,
   output wire [openadc_pkg::SAMPLE_W-1:0]   sample_o,
   output wire                               sample_valid_o,
   output wire                               trigger_o,
   output wire                               armed_o,
   output wire                               capture_active_o,
   output wire                               amp_gain_o
);

   wire [openadc_pkg::SAMPLE_W-1:0] front_sample;
   wire                             front_valid;
   wire [openadc_pkg::SAMPLE_W-1:0] trig_sample;
   wire                             trig_valid;
   wire [openadc_pkg::SAMPLE_W-1:0] trig_level;
   wire [openadc_pkg::LEN_W-1:0]    capture_len;
   wire                             use_adc;
   wire                             arm_pulse;
   wire                             overflow;

   adc_front u_adc_front (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .adc_valid_i    (adc_valid_i),
      .use_adc_i      (use_adc),
      .sample_o       (front_sample),
      .sample_valid_o (front_valid)
   );

   level_trigger u_level_trigger (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .sample_i       (front_sample),
      .sample_valid_i (front_valid),
      .trig_level_i   (trig_level),
      .arm_i          (arm_pulse),
      .sample_o       (trig_sample),
      .sample_valid_o (trig_valid),
      .trig_pulse_o   (trigger_o),
      .armed_o        (armed_o)
   );

   capture_buffer u_capture_buffer (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .sample_i         (trig_sample),
      .sample_valid_i   (trig_valid),
      .trig_pulse_i     (trigger_o),
      .capture_len_i    (capture_len),
      .arm_i            (arm_pulse),
      .sample_ready_i   (sample_ready_i),
      .sample_o         (sample_o),
      .sample_valid_o   (sample_valid_o),
      .capture_active_o (capture_active_o),
      .overflow_o       (overflow)
   );

   openadc_regs u_openadc_regs (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .reg_address_i    (reg_address_i),
      .reg_datai_i      (reg_datai_i),
      .reg_write_i      (reg_write_i),
      .armed_i          (armed_o),
      .capture_active_i (capture_active_o),
      .triggered_i      (trigger_o),
      .overflow_i       (overflow),
      .reg_datao_o      (reg_datao_o),
      .trig_level_o     (trig_level),
      .use_adc_o        (use_adc),
      .capture_len_o    (capture_len),
      .arm_o            (arm_pulse),
      .amp_gain_o       (amp_gain_o)
   );

endmodule

`default_nettype wire

//--- hdl/openadc_pkg.sv
`default_nettype none

package openadc_pkg;

   localparam int SAMPLE_W   = 12;   // adc sample width
   localparam int BYTE_W     = 8;    // register data
   localparam int ADDR_W     = 8;    // register address
   localparam int LEN_W      = 16;   // capture length
   localparam int FIFO_DEPTH = 16;   // capture buffer entries
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   // register map, byte wide
   typedef enum logic [ADDR_W-1:0] {
      REG_GAIN    = 8'h00,
      REG_TRIG_LO = 8'h01,   // level bits 7:0
      REG_TRIG_HI = 8'h02,   // level bits 11:8 in low nibble
      REG_CTRL    = 8'h03,   // bit 0 source, bit 1 arm
      REG_LEN_LO  = 8'h04,
      REG_LEN_HI  = 8'h05,
      REG_STATUS  = 8'h06    // read only
   } reg_addr_e;

   // shared by trigger and capture control
   typedef enum logic [1:0] {
      CAP_IDLE  = 2'd0,
      CAP_ARMED = 2'd1,
      CAP_RUN   = 2'd2
   } cap_state_e;

   // bit positions in the status byte
   localparam int STATUS_ARMED          = 0;
   localparam int STATUS_CAPTURE_ACTIVE = 1;
   localparam int STATUS_TRIGGERED      = 2;
   localparam int STATUS_OVERFLOW       = 7;

   // control register bits
   localparam int CTRL_USE_ADC = 0;
   localparam int CTRL_ARM     = 1;

endpackage

`default_nettype wire

//--- hdl/openadc_regs.sv
`default_nettype none

module openadc_regs (
   input  wire                               clk_usb,
   input  wire                               reset,
   input  wire [openadc_pkg::ADDR_W-1:0]     reg_address_i,
   input  wire [openadc_pkg::BYTE_W-1:0]     reg_datai_i,
   input  wire                               reg_write_i,
   input  wire                               armed_i,
   input  wire                               capture_active_i,
   input  wire                               triggered_i,
   input  wire                               overflow_i,
   output logic [openadc_pkg::BYTE_W-1:0]    reg_datao_o,
   output logic [openadc_pkg::SAMPLE_W-1:0]  trig_level_o,
   output logic                              use_adc_o,
   output logic [openadc_pkg::LEN_W-1:0]     capture_len_o,
   output logic                              arm_o,
   output logic                              amp_gain_o
);

   openadc_pkg::reg_addr_e addr;
   logic [openadc_pkg::BYTE_W-1:0]                     gain_q;
   logic [openadc_pkg::BYTE_W-1:0]                     trig_lo_q;
   logic [openadc_pkg::SAMPLE_W-openadc_pkg::BYTE_W-1:0] trig_hi_q;
   logic [openadc_pkg::BYTE_W-1:0]                     len_lo_q;
   logic [openadc_pkg::BYTE_W-1:0]                     len_hi_q;
   logic                                               triggered_q;
   logic [openadc_pkg::BYTE_W-1:0]                     status;
   logic [openadc_pkg::BYTE_W-1:0]                     rd_mux;
   logic [openadc_pkg::BYTE_W:0]                       pwm_acc;   // msb is the carry

   assign addr = openadc_pkg::reg_addr_e'(reg_address_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q    <= '0;
         trig_lo_q <= '0;
         trig_hi_q <= '0;
         use_adc_o <= 1'b0;
         len_lo_q  <= '0;
         len_hi_q  <= '0;
         arm_o     <= 1'b0;
      end else begin
         arm_o <= 1'b0;   // single cycle pulse
         if (reg_write_i) begin
            case (addr)
               openadc_pkg::REG_GAIN:    gain_q    <= reg_datai_i;
               openadc_pkg::REG_TRIG_LO: trig_lo_q <= reg_datai_i;
               openadc_pkg::REG_TRIG_HI:
                  trig_hi_q <= reg_datai_i[openadc_pkg::SAMPLE_W-openadc_pkg::BYTE_W-1:0];
               openadc_pkg::REG_CTRL: begin
                  use_adc_o <= reg_datai_i[openadc_pkg::CTRL_USE_ADC];
                  arm_o     <= reg_datai_i[openadc_pkg::CTRL_ARM];
               end
               openadc_pkg::REG_LEN_LO:  len_lo_q  <= reg_datai_i;
               openadc_pkg::REG_LEN_HI:  len_hi_q  <= reg_datai_i;
               default: ;   // status is read only
            endcase
         end
      end
   end

   assign trig_level_o  = {trig_hi_q, trig_lo_q};
   assign capture_len_o = {len_hi_q, len_lo_q};

   // set by the trigger, cleared by the next arm
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         triggered_q <= 1'b0;
      end else if (triggered_i) begin
         triggered_q <= 1'b1;
      end else if (arm_o) begin
         triggered_q <= 1'b0;
      end
   end

   always_comb begin
      status = '0;
      status[openadc_pkg::STATUS_ARMED]          = armed_i;
      status[openadc_pkg::STATUS_CAPTURE_ACTIVE] = capture_active_i;
      status[openadc_pkg::STATUS_TRIGGERED]      = triggered_q;
      status[openadc_pkg::STATUS_OVERFLOW]       = overflow_i;
   end

   always_comb begin
      case (addr)
         openadc_pkg::REG_GAIN:    rd_mux = gain_q;
         openadc_pkg::REG_TRIG_LO: rd_mux = trig_lo_q;
         openadc_pkg::REG_TRIG_HI: rd_mux = {{(2*openadc_pkg::BYTE_W-openadc_pkg::SAMPLE_W){1'b0}},
                                             trig_hi_q};
         openadc_pkg::REG_CTRL:    rd_mux = {{(openadc_pkg::BYTE_W-1){1'b0}}, use_adc_o};
         openadc_pkg::REG_LEN_LO:  rd_mux = len_lo_q;
         openadc_pkg::REG_LEN_HI:  rd_mux = len_hi_q;
         openadc_pkg::REG_STATUS:  rd_mux = status;
         default:                  rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset) reg_datao_o <= '0;
      else       reg_datao_o <= rd_mux;
   end

   // carry rate is gain/256
   always_ff @(posedge clk_usb) begin
      if (reset) pwm_acc <= '0;
      else       pwm_acc <= {1'b0, pwm_acc[openadc_pkg::BYTE_W-1:0]} + {1'b0, gain_q};
   end

   assign amp_gain_o = pwm_acc[openadc_pkg::BYTE_W];

endmodule

`default_nettype wire

//--- sim/openadc_checker.sv
`default_nettype none

module openadc_checker (
   input wire                              clk_usb,
   input wire                              reset,
   input wire [openadc_pkg::SAMPLE_W-1:0]  adc_data_i,
   input wire                              adc_valid_i,
   input wire [openadc_pkg::SAMPLE_W-1:0]  sample_i,
   input wire                              sample_valid_i,
   input wire                              ready_i,
   input wire                              trigger_i,
   input wire                              amp_gain_i
);
   timeunit 1ns;
   timeprecision 1ps;

   typedef logic [openadc_pkg::SAMPLE_W-1:0] smp_q_t [$];

   smp_q_t driven;     // valid inputs since the test started
   smp_q_t captured;   // output transfers
   smp_q_t expect_q;
   logic [openadc_pkg::SAMPLE_W-1:0] pattern;   // model of the counting source
   logic [openadc_pkg::SAMPLE_W-1:0] level;
   string test_name;
   bit    recording;
   bit    use_adc;
   bit    gain_on;
   int    len;
   int    trig_seen;
   int    gain_cnt;
   int    n_captured;
   int    test_errs;
   int    n_pass;
   int    n_fail;

   // first sample past the level and the next n-1 valid samples
   function automatic smp_q_t ref_capture(smp_q_t smp, logic [11:0] lvl, int n);
      smp_q_t exp;
      int     first;
      int     i;
      bit     hit;
      first = -1;
      if (n == 0) n = 1;   // zero length still takes the trigger sample
      for (i = 0; i < smp.size() && first < 0; i++) begin
         hit = lvl[11] ? (smp[i] > lvl) : (smp[i] < lvl);
         if (hit) first = i;
      end
      for (i = first; first >= 0 && i < smp.size() && i < first + n; i++) begin
         exp.push_back(smp[i]);
      end
      return exp;
   endfunction

   always @(negedge clk_usb) begin
      if (reset) begin
         pattern = '0;
      end else begin
         if (recording && sample_valid_i && ready_i) begin   // transfer on the next edge
            expect_q = ref_capture(driven, level, len);
            if (n_captured >= expect_q.size()) begin
               $display("Unexpected extra sample on sample_o at %0d ns", $time);
               test_errs++;
            end else if (sample_i !== expect_q[n_captured]) begin
               $display("Error at %0d ns: sample_o expected %03h, got %03h",
                        $time, expect_q[n_captured], sample_i);
               test_errs++;
            end
            captured.push_back(sample_i);
            n_captured++;
         end
         if (recording && trigger_i) trig_seen++;
         if (gain_on && amp_gain_i) gain_cnt++;
         if (adc_valid_i) begin
            if (recording) driven.push_back(use_adc ? adc_data_i : pattern);
            pattern = pattern + 1'b1;   // wraps at 4096
         end
      end
   end

   task automatic check_value(input string sig, input int exp, input int act);
      if (exp !== act) begin
         $display("Error at %0d ns: %s expected %0h, got %0h", $time, sig, exp, act);
         test_errs++;
      end
   endtask

   task automatic begin_test(input string name, input bit cap, input bit src_adc,
                             input logic [11:0] lvl, input int n);
      test_name = name;
      test_errs = 0;
      driven.delete();
      captured.delete();
      n_captured = 0;
      trig_seen = 0;
      use_adc = src_adc;
      level = lvl;
      len = n;
      recording = cap;
   endtask

   task automatic end_capture(input int lo, input int hi, input bit step_chk);
      int i;
      recording = 0;
      if (n_captured < lo || n_captured > hi) begin
         $display("Capture delivered %0d samples instead of %0d to %0d", n_captured, lo, hi);
         test_errs++;
      end
      if (trig_seen != 1) begin
         $display("trigger_o pulsed %0d times instead of once", trig_seen);
         test_errs++;
      end
      for (i = 1; step_chk && i < n_captured; i++) begin
         check_value("sample_o step", (captured[i-1] + 1) % 4096, captured[i]);
      end
   endtask

   task automatic gain_window(input bit on);
      if (on) gain_cnt = 0;
      gain_on = on;
   endtask

   task automatic end_test();
      if (test_errs == 0) n_pass++;
      else                n_fail++;
      $display("test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "pass" : "FAIL",
               test_errs);
   endtask

   task automatic report_counts();
      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
   endtask

endmodule

`default_nettype wire

//--- sim/tb_openadc.sv
`default_nettype none

module tb_openadc;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_NS   = 100;
   localparam int DRIVE_NS = 10;   // inputs change this long after the edge
   localparam int OVF_LEN  = openadc_pkg::FIFO_DEPTH + 4;
   localparam int WATCHDOG_CYCLES = (8 + 8 + 8 + OVF_LEN + 256) * 4 + 1000;

   logic                             clk_usb;
   logic                             reset;
   logic [openadc_pkg::SAMPLE_W-1:0] adc_data_i;
   logic                             adc_valid_i;
   logic [openadc_pkg::ADDR_W-1:0]   reg_address_i;
   logic [openadc_pkg::BYTE_W-1:0]   reg_datai_i;
   logic                             reg_write_i;
   logic                             sample_ready_i;
   logic [openadc_pkg::BYTE_W-1:0]   reg_datao_o;
   logic [openadc_pkg::SAMPLE_W-1:0] sample_o;
   logic                             sample_valid_o;
   logic                             trigger_o;
   logic                             armed_o;
   logic                             capture_active_o;
   logic                             amp_gain_o;
   logic [31:0]                      rng_state = 32'd81020;
   logic [31:0]                      rnd;
   logic [7:0]                       rd_data;
   int                               a;

   openadc_core dut (.*);

   openadc_checker chk (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .adc_valid_i    (adc_valid_i),
      .sample_i       (sample_o),
      .sample_valid_i (sample_valid_o),
      .ready_i        (sample_ready_i),
      .trigger_i      (trigger_o),
      .amp_gain_i     (amp_gain_o)
   );

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_NS / 2) clk_usb = ~clk_usb;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic step();
      @(posedge clk_usb);
      #DRIVE_NS;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      reg_address_i = addr;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      step();
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      reg_address_i = addr;
      step();
      data = reg_datao_o;   // registered view of the address
   endtask

   task automatic arm_capture(input string name, input bit src, input logic [11:0] lvl,
                              input int n);
      chk.begin_test(name, 1'b1, src, lvl, n);
      write_reg(openadc_pkg::REG_TRIG_LO, lvl[7:0]);
      write_reg(openadc_pkg::REG_TRIG_HI, {4'h0, lvl[11:8]});
      write_reg(openadc_pkg::REG_LEN_LO, n[7:0]);
      write_reg(openadc_pkg::REG_LEN_HI, n[15:8]);
      write_reg(openadc_pkg::REG_CTRL, (8'd1 << openadc_pkg::CTRL_ARM) | src);
      step();
      step();   // arm pulse has reached the trigger
      chk.check_value("armed_o", 1, armed_o);
   endtask

   // ready is high in mode 0, random in mode 1 and low in mode 2
   task automatic stream(input int ready_mode);
      bit fired;
      fired = 1'b0;
      do begin
         rnd = next_rand();
         adc_valid_i    = (rnd[1:0] != 2'b00);   // about one gap in four
         adc_data_i     = rnd[27:16];
         sample_ready_i = (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? rnd[8] : 1'b0;
         step();
         if (trigger_o) fired = 1'b1;
      end while (!fired || capture_active_o);
      adc_valid_i = 1'b0;
   endtask

   task automatic drain(input int lo);
      sample_ready_i = 1'b1;
      do step(); while (chk.n_captured < lo || sample_valid_o);
   endtask

   initial begin
      reset = 1'b1;
      adc_data_i = '0;
      adc_valid_i = 1'b0;
      reg_address_i = '0;
      reg_datai_i = '0;
      reg_write_i = 1'b0;
      sample_ready_i = 1'b0;
      repeat (10) @(posedge clk_usb);
      #DRIVE_NS reset = 1'b0;

      chk.begin_test("reset values", 1'b0, 1'b0, '0, 0);
      for (a = 0; a <= openadc_pkg::REG_STATUS; a++) begin
         read_reg(a[7:0], rd_data);
         chk.check_value($sformatf("reg_datao_o at %0h", a), 0, rd_data);
      end
      chk.check_value("armed_o", 0, armed_o);
      chk.check_value("trigger_o", 0, trigger_o);
      chk.check_value("capture_active_o", 0, capture_active_o);
      chk.check_value("sample_valid_o", 0, sample_valid_o);
      chk.check_value("amp_gain_o", 0, amp_gain_o);
      chk.end_test();

      arm_capture("above level, adc source", 1'b1, 12'h900, 8);
      stream(0);
      drain(8);
      read_reg(openadc_pkg::REG_STATUS, rd_data);
      chk.check_value("status armed", 0, rd_data[openadc_pkg::STATUS_ARMED]);
      chk.check_value("status triggered", 1, rd_data[openadc_pkg::STATUS_TRIGGERED]);
      chk.end_capture(8, 8, 1'b0);
      chk.end_test();

      arm_capture("below level, ready stalls", 1'b1, 12'h400, 8);
      stream(1);
      drain(8);
      read_reg(openadc_pkg::REG_STATUS, rd_data);
      chk.check_value("status overflow", 0, rd_data[openadc_pkg::STATUS_OVERFLOW]);
      chk.end_capture(8, 8, 1'b0);
      chk.end_test();

      arm_capture("test pattern source", 1'b0, 12'h7ff, 8);
      stream(0);
      drain(8);
      chk.end_capture(8, 8, 1'b1);
      chk.end_test();

      arm_capture("overflow", 1'b1, 12'h900, OVF_LEN);
      stream(2);
      read_reg(openadc_pkg::REG_STATUS, rd_data);
      chk.check_value("status overflow", 1, rd_data[openadc_pkg::STATUS_OVERFLOW]);
      write_reg(openadc_pkg::REG_CTRL, (8'd1 << openadc_pkg::CTRL_ARM) | 8'd1);
      step();
      read_reg(openadc_pkg::REG_STATUS, rd_data);
      chk.check_value("status overflow after arm", 0, rd_data[openadc_pkg::STATUS_OVERFLOW]);
      drain(openadc_pkg::FIFO_DEPTH);
      chk.end_capture(openadc_pkg::FIFO_DEPTH, OVF_LEN - 1, 1'b0);
      chk.end_test();

      chk.begin_test("gain output", 1'b0, 1'b0, '0, 0);
      rnd = next_rand();
      write_reg(openadc_pkg::REG_GAIN, rnd[7:0]);
      read_reg(openadc_pkg::REG_GAIN, rd_data);
      chk.check_value("reg_datao_o gain", rnd[7:0], rd_data);
      chk.gain_window(1'b1);
      repeat (256) step();
      chk.gain_window(1'b0);
      chk.check_value("amp_gain_o high cycles", rnd[7:0], chk.gain_cnt);
      chk.end_test();

      chk.report_counts();
      if (chk.n_fail == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_NS);
      $display("Watchdog expired after %0d cycles, the test sequence did not finish",
               WATCHDOG_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
